// ==== logic/core_pkg.sv ====
package core_pkg;

  typedef logic [31:0] data_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [15:0] imm_t;
  typedef logic [4:0]  shamt_t;

  // opcode lives in instr[31:26]
  typedef enum logic [5:0] {
    OP_ADD  = 6'h01,
    OP_SUB  = 6'h02,
    OP_AND  = 6'h03,
    OP_OR   = 6'h04,
    OP_XOR  = 6'h05,
    OP_SLT  = 6'h06,
    OP_SLL  = 6'h07,
    OP_ADDI = 6'h08,
    OP_ORI  = 6'h09
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL
  } alu_op_t;

  typedef struct packed {
    alu_op_t   alu_op;
    logic      use_imm;
    logic      reg_write;
    reg_addr_t dest;
    reg_addr_t rs;
    reg_addr_t rt;
    imm_t      imm;
    shamt_t    shamt;
  } decoded_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t dest;
    data_t     data;
  } retire_t;

  typedef enum logic [0:0] {
    HS_WAIT_REQ,
    HS_WAIT_RELEASE
  } hs_state_t;

endpackage

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder import core_pkg::*; (
  input  instr_t   instr,
  output decoded_t decoded
);

  opcode_t   opcode;
  reg_addr_t rd;
  logic      known;
  logic      dest_is_rt;

  assign opcode = opcode_t'(instr[31:26]);
  assign rd     = instr[15:11];

  always_comb begin
    decoded.alu_op = ALU_ADD;
    decoded.use_imm = 1'b0;
    dest_is_rt = 1'b0;
    known = 1'b1;
    case (opcode)
      OP_ADD: decoded.alu_op = ALU_ADD;
      OP_SUB: decoded.alu_op = ALU_SUB;
      OP_AND: decoded.alu_op = ALU_AND;
      OP_OR:  decoded.alu_op = ALU_OR;
      OP_XOR: decoded.alu_op = ALU_XOR;
      OP_SLT: decoded.alu_op = ALU_SLT;
      OP_SLL: decoded.alu_op = ALU_SLL;
      OP_ADDI: begin
        decoded.alu_op = ALU_ADD;
        decoded.use_imm = 1'b1;
        dest_is_rt = 1'b1;
      end
      OP_ORI: begin
        decoded.alu_op = ALU_OR;
        decoded.use_imm = 1'b1;
        dest_is_rt = 1'b1;
      end
      default: known = 1'b0;
    endcase

    decoded.rs    = instr[25:21];
    decoded.rt    = instr[20:16];
    decoded.imm   = instr[15:0];
    decoded.shamt = instr[10:6];
    decoded.dest  = dest_is_rt ? decoded.rt : rd;
    // no write for unknown ops or r0
    decoded.reg_write = known && (decoded.dest != '0);
  end

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/1ps

module register_file import core_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  reg_addr_t rd_addr_a,
  input  reg_addr_t rd_addr_b,
  output data_t     rd_data_a,
  output data_t     rd_data_b,
  input  logic      wr_en,
  input  reg_addr_t wr_addr,
  input  data_t     wr_data
);

  // r0 has no storage
  data_t regs [1:31];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
  assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import core_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      accept,
  input  logic      ex_valid,
  input  logic      fwd_a,
  input  logic      fwd_b,
  input  decoded_t  decoded,
  input  data_t     rf_a,
  input  data_t     rf_b,
  output reg_addr_t wb_dest,
  output data_t     wb_data,
  output retire_t   retire
);

  decoded_t ex_dec;
  data_t    ex_a;
  data_t    ex_b;
  data_t    alu_b;
  data_t    alu_result;
  logic     wb_load;
  logic     wb_valid;

  ////////////////////////////////////////////////////////////
  // operand register

  // wb_data holds the previous result at the earliest accept
  always_ff @(posedge clk) begin
    if (accept) begin
      ex_dec <= decoded;
      ex_a   <= fwd_a ? wb_data : rf_a;
      ex_b   <= fwd_b ? wb_data : rf_b;
    end
  end

  ////////////////////////////////////////////////////////////
  // alu

  // immediates are zero-extended
  assign alu_b = ex_dec.use_imm ? {16'h0000, ex_dec.imm} : ex_b;

  always_comb begin
    case (ex_dec.alu_op)
      ALU_ADD: alu_result = ex_a + alu_b;
      ALU_SUB: alu_result = ex_a - alu_b;
      ALU_AND: alu_result = ex_a & alu_b;
      ALU_OR:  alu_result = ex_a | alu_b;
      ALU_XOR: alu_result = ex_a ^ alu_b;
      ALU_SLT: alu_result = {31'b0, $signed(ex_a) < $signed(alu_b)};
      // shifts the rt value
      ALU_SLL: alu_result = ex_b << ex_dec.shamt;
      default: alu_result = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // writeback register

  assign wb_load = ex_valid && ex_dec.reg_write;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= wb_load;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_load) begin
      wb_dest <= ex_dec.dest;
      wb_data <= alu_result;
    end
  end

  // one-cycle report, rf is written at the end of it
  assign retire.valid = wb_valid;
  assign retire.dest  = wb_dest;
  assign retire.data  = wb_data;

endmodule

// ==== logic/pipeline_control.sv ====
`timescale 1ns/1ps

module pipeline_control import core_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      req,
  output logic      ack,
  input  decoded_t  decoded,
  input  reg_addr_t wb_dest,
  output logic      accept,
  output logic      ex_valid,
  output logic      fwd_a,
  output logic      fwd_b,
  output logic      rf_wr_en
);

  hs_state_t state;
  hs_state_t state_next;
  logic      ex_write;
  logic      wb_valid;

  ////////////////////////////////////////////////////////////
  // four-phase handshake

  always_comb begin
    state_next = state;
    case (state)
      HS_WAIT_REQ: begin
        if (req) begin
          state_next = HS_WAIT_RELEASE;
        end
      end
      HS_WAIT_RELEASE: begin
        if (!req) begin
          state_next = HS_WAIT_REQ;
        end
      end
      default: state_next = HS_WAIT_REQ;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= HS_WAIT_REQ;
      ex_valid <= 1'b0;
      ex_write <= 1'b0;
      wb_valid <= 1'b0;
    end else begin
      state    <= state_next;
      ex_valid <= accept;
      if (accept) begin
        ex_write <= decoded.reg_write;
      end
      wb_valid <= ex_valid && ex_write;
    end
  end

  // ack is high for the whole time in wait_release
  assign ack    = (state == HS_WAIT_RELEASE);
  assign accept = (state == HS_WAIT_REQ) && req;

  ////////////////////////////////////////////////////////////
  // forwarding and rf write

  // wb dest is never r0 when valid
  assign fwd_a    = wb_valid && (decoded.rs == wb_dest);
  assign fwd_b    = wb_valid && (decoded.rt == wb_dest);
  assign rf_wr_en = wb_valid;

endmodule

// ==== logic/scalar_core.sv ====
`timescale 1ns/1ps

module scalar_core import core_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    req,
  output logic    ack,
  input  instr_t  instr,
  output retire_t retire
);

  decoded_t  decoded;
  data_t     rf_a;
  data_t     rf_b;
  reg_addr_t wb_dest;
  data_t     wb_data;
  logic      accept;
  logic      ex_valid;
  logic      fwd_a;
  logic      fwd_b;
  logic      rf_wr_en;

  instr_decoder u_decoder (
    .instr   (instr),
    .decoded (decoded)
  );

  register_file u_regfile (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_addr_a (decoded.rs),
    .rd_addr_b (decoded.rt),
    .rd_data_a (rf_a),
    .rd_data_b (rf_b),
    .wr_en     (rf_wr_en),
    .wr_addr   (wb_dest),
    .wr_data   (wb_data)
  );

  pipeline_control u_control (
    .clk      (clk),
    .arst_n   (arst_n),
    .req      (req),
    .ack      (ack),
    .decoded  (decoded),
    .wb_dest  (wb_dest),
    .accept   (accept),
    .ex_valid (ex_valid),
    .fwd_a    (fwd_a),
    .fwd_b    (fwd_b),
    .rf_wr_en (rf_wr_en)
  );

  execute_stage u_execute (
    .clk      (clk),
    .arst_n   (arst_n),
    .accept   (accept),
    .ex_valid (ex_valid),
    .fwd_a    (fwd_a),
    .fwd_b    (fwd_b),
    .decoded  (decoded),
    .rf_a     (rf_a),
    .rf_b     (rf_b),
    .wb_dest  (wb_dest),
    .wb_data  (wb_data),
    .retire   (retire)
  );

endmodule

// ==== sim/scalar_core_checker.sv ====
`timescale 1ns/1ps

module scalar_core_checker import core_pkg::*; (
  input logic    clk,
  input logic    arst_n,
  input logic    req,
  input logic    ack,
  input retire_t retire
);

  logic accepted;
  int   failures = 0;

  // the core sits in wait_req exactly while ack is low
  assign accepted = req && !ack;

  ack_rise_with_req: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(ack) |-> $past(req))
  else begin
    failures++;
    $error("ack rose without a pending req");
  end

  ack_fall_after_release: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(ack) |-> !$past(req))
  else begin
    failures++;
    $error("ack fell while req was still high");
  end

  retire_not_r0: assert property (@(posedge clk) disable iff (!arst_n)
    retire.valid |-> (retire.dest != '0))
  else begin
    failures++;
    $error("retire reported register 0");
  end

  retire_after_accept: assert property (@(posedge clk) disable iff (!arst_n)
    retire.valid |-> $past(accepted, 2))
  else begin
    failures++;
    $error("retire without an accept two cycles back");
  end

endmodule

// ==== sim/scalar_core_tb.sv ====
`timescale 1ns/1ps

module scalar_core_tb import core_pkg::*; ();

  localparam int num_vectors = 22;
  localparam int num_random  = 40;
  localparam int hs_limit    = 8;
  localparam int watchdog_ns = (num_vectors + num_random) * 10 * 20;

  typedef struct packed {
    instr_t    word;
    logic      valid;
    reg_addr_t dest;
    data_t     data;
  } vector_t;

  logic    clk;
  logic    arst_n;
  logic    req;
  logic    ack;
  instr_t  instr;
  retire_t retire;
  vector_t vectors [num_vectors];
  data_t   model_regs [32];
  int      errors;
  int      checks;
  integer  seed;

  scalar_core uut (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .ack    (ack),
    .instr  (instr),
    .retire (retire)
  );

  bind scalar_core scalar_core_checker u_checker (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .ack    (ack),
    .retire (retire)
  );

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("[FAIL] %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic instr_t r_word(input logic [5:0] op, input reg_addr_t rs, input reg_addr_t rt,
                                    input reg_addr_t rd, input shamt_t shamt);
    return {op, rs, rt, rd, shamt, 6'b000000};
  endfunction

  function automatic instr_t i_word(input logic [5:0] op, input reg_addr_t rs, input reg_addr_t rt,
                                    input imm_t imm);
    return {op, rs, rt, imm};
  endfunction

  // reference results for the random mix with zero-extended immediates
  function automatic data_t predict(input logic [5:0] op, input data_t a, input data_t b,
                                    input imm_t imm);
    data_t ext;
    ext = {16'h0000, imm};
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_XOR:  return a ^ b;
      OP_ADDI: return a + ext;
      OP_ORI:  return a | ext;
      default: return '0;
    endcase
  endfunction

  task automatic set_vector(input int idx, input instr_t word, input logic valid,
                            input reg_addr_t dest, input data_t data);
    vectors[idx] = {word, valid, dest, data};
  endtask

  task automatic build_vectors();
    set_vector(0, i_word(OP_ADDI, 5'd0, 5'd1, 16'h1234), 1'b1, 5'd1, 32'h00001234);
    set_vector(1, i_word(OP_ORI, 5'd0, 5'd2, 16'hf00f), 1'b1, 5'd2, 32'h0000f00f);
    set_vector(2, i_word(OP_ADDI, 5'd0, 5'd3, 16'h8000), 1'b1, 5'd3, 32'h00008000);
    set_vector(3, r_word(OP_ADD, 5'd1, 5'd2, 5'd4, 5'd0), 1'b1, 5'd4, 32'h00010243);
    set_vector(4, r_word(OP_SUB, 5'd1, 5'd2, 5'd5, 5'd0), 1'b1, 5'd5, 32'hffff2225);
    set_vector(5, r_word(OP_AND, 5'd2, 5'd3, 5'd6, 5'd0), 1'b1, 5'd6, 32'h00008000);
    set_vector(6, r_word(OP_OR, 5'd1, 5'd3, 5'd7, 5'd0), 1'b1, 5'd7, 32'h00009234);
    set_vector(7, r_word(OP_XOR, 5'd1, 5'd2, 5'd8, 5'd0), 1'b1, 5'd8, 32'h0000e23b);
    set_vector(8, r_word(OP_SLT, 5'd5, 5'd1, 5'd9, 5'd0), 1'b1, 5'd9, 32'h00000001);
    set_vector(9, r_word(OP_SLT, 5'd1, 5'd5, 5'd10, 5'd0), 1'b1, 5'd10, 32'h00000000);
    set_vector(10, r_word(OP_SLL, 5'd0, 5'd1, 5'd11, 5'd4), 1'b1, 5'd11, 32'h00012340);
    // dependent chain at the earliest handshake
    set_vector(11, i_word(OP_ADDI, 5'd0, 5'd12, 16'h0011), 1'b1, 5'd12, 32'h00000011);
    set_vector(12, r_word(OP_ADD, 5'd12, 5'd1, 5'd13, 5'd0), 1'b1, 5'd13, 32'h00001245);
    set_vector(13, r_word(OP_SUB, 5'd1, 5'd13, 5'd14, 5'd0), 1'b1, 5'd14, 32'hffffffef);
    set_vector(14, i_word(OP_ADDI, 5'd14, 5'd14, 16'h0001), 1'b1, 5'd14, 32'hfffffff0);
    set_vector(15, r_word(OP_SLL, 5'd0, 5'd14, 5'd15, 5'd1), 1'b1, 5'd15, 32'hffffffe0);
    set_vector(16, r_word(OP_XOR, 5'd15, 5'd15, 5'd16, 5'd0), 1'b1, 5'd16, 32'h00000000);
    // no retire for r0 targets or unknown opcodes
    set_vector(17, i_word(OP_ADDI, 5'd0, 5'd0, 16'h5555), 1'b0, 5'd0, 32'h00000000);
    set_vector(18, r_word(OP_ADD, 5'd1, 5'd2, 5'd0, 5'd0), 1'b0, 5'd0, 32'h00000000);
    set_vector(19, r_word(6'h3f, 5'd1, 5'd2, 5'd17, 5'd0), 1'b0, 5'd0, 32'h00000000);
    set_vector(20, r_word(OP_OR, 5'd0, 5'd0, 5'd17, 5'd0), 1'b1, 5'd17, 32'h00000000);
    set_vector(21, r_word(OP_ADD, 5'd0, 5'd1, 5'd18, 5'd0), 1'b1, 5'd18, 32'h00001234);
  endtask

  // one four-phase handshake with retire sampled on each falling edge
  task automatic send_instr(input int idx, input instr_t word, input logic exp_valid,
                            input reg_addr_t exp_dest, input data_t exp_data);
    int      cycles;
    int      ack_cycle;
    int      seen;
    int      seen_cycle;
    retire_t seen_retire;
    cycles = 0;
    ack_cycle = 0;
    seen = 0;
    seen_cycle = 0;
    seen_retire = '0;
    instr = word;
    req = 1'b1;
    while ((ack_cycle == 0 || ack) && cycles < hs_limit) begin
      @(negedge clk);
      cycles++;
      if (retire.valid) begin
        seen++;
        seen_cycle = cycles;
        seen_retire = retire;
      end
      if (ack && ack_cycle == 0) begin
        ack_cycle = cycles;
        req = 1'b0;
      end
    end
    if (ack_cycle == 0 || ack) begin
      $display("handshake for instruction %0d did not complete", idx);
      errors++;
      req = 1'b0;
    end else begin
      // ack one cycle after the accept edge, low again one cycle later
      check_value("ack rise cycle", ack_cycle, 1);
      check_value("ack high cycles", cycles - ack_cycle, 1);
    end
    if (exp_valid && seen == 0) begin
      $display("missing retire for instruction %0d", idx);
      errors++;
    end else begin
      check_value("retire count", seen, exp_valid ? 1 : 0);
      if (seen > 0) begin
        check_value("retire.dest", 32'(seen_retire.dest), 32'(exp_dest));
        check_value("retire.data", seen_retire.data, exp_data);
        check_value("retire cycle after ack", seen_cycle - ack_cycle, 1);
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired, the core stopped answering the handshake");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    logic [31:0] pick;
    logic [31:0] fields;
    logic [5:0]  op;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   dest;
    logic        is_imm;
    instr_t      word;
    data_t       value;
    errors = 0;
    checks = 0;
    seed = 32'h7cdf880b;
    arst_n = 1'b0;
    req = 1'b0;
    instr = '0;
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
    build_vectors();
    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    for (int i = 0; i < num_vectors; i++) begin
      send_instr(i, vectors[i].word, vectors[i].valid, vectors[i].dest, vectors[i].data);
      if (vectors[i].valid) begin
        model_regs[vectors[i].dest] = vectors[i].data;
      end
    end

    // random mix over r0..r7 so dependencies come often
    for (int n = 0; n < num_random; n++) begin
      pick = $random(seed);
      fields = $random(seed);
      case (pick % 5)
        0: op = OP_ADD;
        1: op = OP_SUB;
        2: op = OP_XOR;
        3: op = OP_ADDI;
        default: op = OP_ORI;
      endcase
      rs = {2'b00, fields[2:0]};
      rt = {2'b00, fields[5:3]};
      is_imm = (op == OP_ADDI) || (op == OP_ORI);
      dest = is_imm ? rt : {2'b00, fields[8:6]};
      word = is_imm ? i_word(op, rs, rt, fields[31:16])
                    : r_word(op, rs, rt, dest, fields[13:9]);
      value = predict(op, model_regs[rs], model_regs[rt], fields[31:16]);
      send_instr(num_vectors + n, word, dest != '0, dest, value);
      if (dest != '0) begin
        model_regs[dest] = value;
      end
    end

    $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             uut.u_checker.failures);
    if (errors == 0 && uut.u_checker.failures == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== scalar_core.f ====
logic/core_pkg.sv
logic/instr_decoder.sv
logic/register_file.sv
logic/execute_stage.sv
logic/pipeline_control.sv
logic/scalar_core.sv
sim/scalar_core_checker.sv
sim/scalar_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= scalar_core_tb
FILELIST  ?= scalar_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
